/* fetch_stage.f */
+incdir+source
source/fetch_pkg.sv
source/fetch_ctrl.sv
source/fetch_addr.sv
source/fetch_ifb.sv
source/fetch_stage.sv
verif/ahb_rom_model.sv
verif/tb_fetch_stage.sv

/* verif/tb_fetch_stage.sv */
/* Directed testbench for the fetch stage
   Decode stalls whenever no word is expected, so the IFB fills between tests
   Bus is sampled on the falling edge, inputs move 1 ns after the rising edge */

`default_nettype none

`include "fetch_params.svh"

module tb_fetch_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int               CLK_PERIOD  = 10;
    localparam int               TOTAL_WORDS = 84;  // Every word ever queued as expected
    localparam fetch_pkg::word_t ERR_ADDR_A  = 32'h0000_0808;
    localparam fetch_pkg::word_t ERR_ADDR_B  = 32'h0000_0814;

    logic                     s_clk, arst_n;
    fetch_pkg::word_t         haddr, hrdata, redirect_addr, id_instr;
    fetch_pkg::htrans_e       htrans;
    fetch_pkg::fetch_status_e id_status;
    logic                     hready, hresp, redirect, id_stall, id_valid;
    logic                     wait_en, bus_hold, stall_req;  // Test controls

    fetch_pkg::word_t   exp_q[$];       // Byte addresses decode must see next
    fetch_pkg::word_t   next_addr;
    fetch_pkg::word_t   prev_haddr;
    fetch_pkg::htrans_e prev_htrans;
    logic               prev_hready;
    logic               mon_en = 1'b0;
    int                 value_errs = 0;
    int                 other_errs = 0;
    int                 words_seen = 0;

    fetch_stage u_fetch_stage (
        .s_clk_i(s_clk), .arst_n_i(arst_n),
        .haddr_o(haddr), .htrans_o(htrans), .hrdata_i(hrdata),
        .hready_i(hready), .hresp_i(hresp),
        .redirect_i(redirect), .redirect_addr_i(redirect_addr),
        .id_stall_i(id_stall), .id_instr_o(id_instr),
        .id_status_o(id_status), .id_valid_o(id_valid)
    );

    ahb_rom_model #(.ERR_ADDR_A(ERR_ADDR_A), .ERR_ADDR_B(ERR_ADDR_B)) u_rom (
        .s_clk_i(s_clk), .arst_n_i(arst_n), .haddr_i(haddr), .htrans_i(htrans),
        .wait_en_i(wait_en), .hold_i(bus_hold),
        .hrdata_o(hrdata), .hready_o(hready), .hresp_o(hresp)
    );

    function automatic fetch_pkg::fetch_status_e status_for(input fetch_pkg::word_t addr);
        return (addr == ERR_ADDR_A || addr == ERR_ADDR_B) ? fetch_pkg::FETCH_BSERR
                                                          : fetch_pkg::FETCH_VALID;
    endfunction

    task automatic check_instr(input string name, input fetch_pkg::word_t got,
                               input fetch_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic check_haddr(input string name, input fetch_pkg::word_t got,
                               input fetch_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic check_status(input string name, input fetch_pkg::fetch_status_e got,
                                input fetch_pkg::fetch_status_e exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic check_htrans(input string name, input fetch_pkg::htrans_e got,
                                input fetch_pkg::htrans_e exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    // One cycle on, decode stalls while nothing is expected
    task automatic step();
        @(posedge s_clk);
        #1;
        id_stall = stall_req || (exp_q.size() == 0);
    endtask

    task automatic add_expected(input int n);
        repeat (n) begin
            exp_q.push_back(next_addr);
            next_addr = next_addr + 32'd4;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) step();
    endtask

    task automatic redirect_to(input fetch_pkg::word_t target, input int n);
        step();
        redirect      = 1'b1;
        redirect_addr = target;
        exp_q.delete();           // Words from before never reach decode
        next_addr = target;
        add_expected(n);
        id_stall  = stall_req;
        step();
        redirect  = 1'b0;
        bus_hold  = 1'b0;         // Lets a parked target move to FE0
    endtask

    task automatic reset_and_first_words();
        repeat (15) @(posedge s_clk);
        #1;
        check_htrans("htrans_o", htrans, fetch_pkg::HTRANS_IDLE);
        if (id_valid !== 1'b0) begin
            $display("ERROR: id_valid_o is high during reset");
            other_errs++;
        end
        step();
        arst_n = 1'b1;
        mon_en = 1'b1;
        step();                   // First request is on the bus now
        check_haddr("haddr_o", haddr, `FETCH_RESET_ADDR);
        check_htrans("htrans_o", htrans, fetch_pkg::HTRANS_NONSEQ);
        add_expected(16);
        drain();
    endtask

    task automatic wait_state_sequence();
        wait_en = 1'b1;
        add_expected(24);
        drain();
    endtask

    task automatic decode_backpressure();
        add_expected(8);
        stall_req = 1'b1;
        id_stall  = 1'b1;
        repeat (40) step();       // IFB full and fetch paused by now
        repeat (10) begin
            @(negedge s_clk);
            check_htrans("htrans_o", htrans, fetch_pkg::HTRANS_IDLE);
            if (id_valid !== 1'b1) begin
                $display("ERROR: IFB is empty during a long decode stall");
                other_errs++;
            end
        end
        stall_req = 1'b0;
        drain();
    endtask

    task automatic redirect_when_idle();
        repeat (40) step();       // Let the IFB fill and the bus go IDLE
        redirect_to(32'h0000_0400, 6);
        drain();
    endtask

    task automatic redirect_under_wait();
        add_expected(12);
        while (exp_q.size() > 10) step();
        bus_hold = 1'b1;
        @(negedge s_clk);
        // Need a data phase that the bus keeps waiting
        while (hready) @(negedge s_clk);
        redirect_to(32'h0000_0600, 8);
        drain();
    endtask

    task automatic bus_error_status();
        redirect_to(32'h0000_0800, 10);  // Error addresses at 0x808 and 0x814
        drain();
    endtask

    // Decode side and bus checks, all values stable mid-cycle
    always @(negedge s_clk) begin : decode_monitor
        fetch_pkg::word_t exp_addr;
        if (mon_en) begin
            if (!prev_hready) begin
                check_haddr("haddr_o", haddr, prev_haddr);
                check_htrans("htrans_o", htrans, prev_htrans);
            end
            if (id_valid && !id_stall && !redirect) begin  // Popped on the next edge
                if (exp_q.size() == 0) begin
                    $display("ERROR: decode took word 0x%h with none expected", id_instr);
                    other_errs++;
                end else begin
                    exp_addr = exp_q.pop_front();
                    check_instr("id_instr_o", id_instr, exp_addr ^ 32'hA5A5_0000);
                    check_status("id_status_o", id_status, status_for(exp_addr));
                    words_seen++;
                end
            end
        end
        prev_haddr  = haddr;
        prev_htrans = htrans;
        prev_hready = hready;
    end

    initial begin
        s_clk = 1'b0;
        forever #(CLK_PERIOD / 2) s_clk = ~s_clk;
    end

    initial begin
        arst_n        = 1'b0;
        redirect      = 1'b0;
        redirect_addr = '0;
        id_stall      = 1'b1;
        wait_en       = 1'b0;
        bus_hold      = 1'b0;
        stall_req     = 1'b0;
        prev_hready   = 1'b1;
        next_addr     = `FETCH_RESET_ADDR;
        reset_and_first_words();
        wait_state_sequence();
        decode_backpressure();
        redirect_when_idle();
        redirect_under_wait();
        bus_error_status();
        $display("Summary: %0d words, %0d value errors, %0d other errors",
                 words_seen, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TOTAL_WORDS * 40 * CLK_PERIOD + 2000);
        other_errs++;
        $display("ERROR: watchdog timeout, the tests did not finish");
        $display("Summary: %0d words, %0d value errors, %0d other errors",
                 words_seen, value_errs, other_errs);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ahb_rom_model.sv */
/* Reduced AHB-Lite read responder for the fetch stage testbench
   Word at each byte address is the address XOR 32'hA5A5_0000
   Inputs are sampled on the falling edge and outputs move 1 ns after the rising edge
   hold_i keeps a started data phase waiting until it is released */

`default_nettype none

module ahb_rom_model #(
    parameter fetch_pkg::word_t ERR_ADDR_A = 32'hFFFF_FFF0,
    parameter fetch_pkg::word_t ERR_ADDR_B = 32'hFFFF_FFF0
) (
    input  logic               s_clk_i,
    input  logic               arst_n_i,
    input  fetch_pkg::word_t   haddr_i,
    input  fetch_pkg::htrans_e htrans_i,
    input  logic               wait_en_i,  // Random 0 to 3 wait states
    input  logic               hold_i,     // Stretch the data phase
    output fetch_pkg::word_t   hrdata_o,
    output logic               hready_o,
    output logic               hresp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    integer             seed;
    logic               dp_active;    // Data phase in progress
    fetch_pkg::word_t   dp_addr;
    int unsigned        wait_cnt;
    fetch_pkg::word_t   s_addr;
    fetch_pkg::htrans_e s_trans;
    logic               s_ready, s_wait_en, s_hold;

    initial begin
        seed      = 69;
        dp_active = 1'b0;
        wait_cnt  = 0;
        hready_o  = 1'b1;
        hresp_o   = 1'b0;
        hrdata_o  = '0;
    end

    // Mid-cycle sample, nothing moves here
    always @(negedge s_clk_i) begin
        s_addr    = haddr_i;
        s_trans   = htrans_i;
        s_ready   = hready_o;
        s_wait_en = wait_en_i;
        s_hold    = hold_i;
    end

    always @(posedge s_clk_i) begin
        if (!arst_n_i) begin
            dp_active = 1'b0;
            wait_cnt  = 0;
        end else if (s_ready) begin
            // Previous data phase ends, a new address phase is taken
            dp_active = (s_trans == fetch_pkg::HTRANS_NONSEQ);
            dp_addr   = s_addr;
            wait_cnt  = s_wait_en ? {$random(seed)} % 4 : 0;
        end else if (wait_cnt != 0) begin
            wait_cnt = wait_cnt - 1;
        end
        #1;
        if (dp_active && (wait_cnt != 0 || s_hold)) begin
            hready_o = 1'b0;
            hresp_o  = 1'b0;
            hrdata_o = '0;
        end else begin
            hready_o = 1'b1;
            hrdata_o = dp_active ? (dp_addr ^ 32'hA5A5_0000) : '0;
            hresp_o  = dp_active && (dp_addr == ERR_ADDR_A || dp_addr == ERR_ADDR_B);
        end
    end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
/* Fetch stage top with reduced AHB-Lite read port and decode port
   Single word NONSEQ reads only, no bursts
   redirect_i is a one cycle pulse from a later stage */

`default_nettype none

`include "fetch_params.svh"

module fetch_stage (
    input  logic                     s_clk_i,
    input  logic                     arst_n_i,
    // Instruction bus
    output fetch_pkg::word_t         haddr_o,
    output fetch_pkg::htrans_e       htrans_o,
    input  fetch_pkg::word_t         hrdata_i,
    input  logic                     hready_i,
    input  logic                     hresp_i,
    // Redirect from a later stage
    input  logic                     redirect_i,
    input  fetch_pkg::word_t         redirect_addr_i,
    // Decode side
    input  logic                     id_stall_i,
    output fetch_pkg::word_t         id_instr_o,
    output fetch_pkg::fetch_status_e id_status_o,
    output logic                     id_valid_o
);

    fetch_pkg::fe0_src_e      fe0_src;
    fetch_pkg::fe1_src_e      fe1_src;
    fetch_pkg::fetch_status_e ifb_status;
    fetch_pkg::ifb_cnt_t      ifb_cnt;
    logic                     ifb_push, ifb_flush, ifb_pop;

    assign ifb_pop = id_valid_o & ~id_stall_i;  // Word handed to decode

    fetch_ctrl u_fetch_ctrl (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .hready_i     (hready_i),
        .hresp_i      (hresp_i),
        .redirect_i   (redirect_i),
        .ifb_cnt_i    (ifb_cnt),
        .fe0_src_o    (fe0_src),
        .fe1_src_o    (fe1_src),
        .htrans_o     (htrans_o),
        .ifb_push_o   (ifb_push),
        .ifb_status_o (ifb_status),
        .ifb_flush_o  (ifb_flush)
    );

    fetch_addr u_fetch_addr (
        .s_clk_i         (s_clk_i),
        .arst_n_i        (arst_n_i),
        .fe0_src_i       (fe0_src),
        .fe1_src_i       (fe1_src),
        .redirect_addr_i (redirect_addr_i),
        .haddr_o         (haddr_o)
    );

    // Read data goes straight into the IFB
    fetch_ifb u_fetch_ifb (
        .s_clk_i       (s_clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (ifb_flush),
        .push_i        (ifb_push),
        .push_instr_i  (hrdata_i),
        .push_status_i (ifb_status),
        .pop_i         (ifb_pop),
        .instr_o       (id_instr_o),
        .status_o      (id_status_o),
        .valid_o       (id_valid_o),
        .cnt_o         (ifb_cnt)
    );

    // AHB rule for a waited address phase, address and type together
    a_bus_stable: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        !hready_i |=> ($stable(haddr_o) && $stable(htrans_o)));

endmodule

`default_nettype wire

/* source/fetch_ifb.sv */
/* Instruction fetch buffer between the bus and decode
   Flush wins over push and pop of the same edge
   Head word is valid only while valid_o is high */

`default_nettype none

`include "fetch_params.svh"

module fetch_ifb (
    input  logic                     s_clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  logic                     push_i,
    input  fetch_pkg::word_t         push_instr_i,
    input  fetch_pkg::fetch_status_e push_status_i,
    input  logic                     pop_i,
    output fetch_pkg::word_t         instr_o,
    output fetch_pkg::fetch_status_e status_o,
    output logic                     valid_o,
    output fetch_pkg::ifb_cnt_t      cnt_o
);

    localparam int unsigned DEPTH = `FETCH_IFB_DEPTH;
    localparam int unsigned PW    = $clog2(DEPTH);

    fetch_pkg::word_t         instr_mem  [DEPTH];
    fetch_pkg::fetch_status_e status_mem [DEPTH];

    logic [PW-1:0]       wr_ptr_q, rd_ptr_q;
    logic [PW-1:0]       wr_ptr_nxt, rd_ptr_nxt;
    fetch_pkg::ifb_cnt_t cnt_q;
    logic                push_en, pop_en;

    assign push_en = push_i & ~flush_i;
    assign pop_en  = pop_i & ~flush_i;

    // Wrap for any depth, not only powers of two
    assign wr_ptr_nxt = (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
    assign rd_ptr_nxt = (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;  // Drop everything
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_en) wr_ptr_q <= wr_ptr_nxt;
            if (pop_en) rd_ptr_q <= rd_ptr_nxt;
            unique case ({push_en, pop_en})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (push_en) begin
            instr_mem[wr_ptr_q]  <= push_instr_i;
            status_mem[wr_ptr_q] <= push_status_i;
        end
    end

    assign instr_o  = instr_mem[rd_ptr_q];
    assign status_o = status_mem[rd_ptr_q];
    assign valid_o  = cnt_q != '0;
    assign cnt_o    = cnt_q;

    // A push into a full buffer would overwrite the head word
    a_no_overflow: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        (push_en && !pop_en) |-> (cnt_q < fetch_pkg::ifb_cnt_t'(DEPTH)));

endmodule

`default_nettype wire

/* source/fetch_addr.sv */
/* Address registers of FE0 and FE1 with the sequential incrementer
   Registers hold word addresses so fetch is word aligned only
   Selects come from fetch_ctrl and take effect one edge later */

`default_nettype none

`include "fetch_params.svh"

module fetch_addr (
    input  logic                s_clk_i,
    input  logic                arst_n_i,
    input  fetch_pkg::fe0_src_e fe0_src_i,
    input  fetch_pkg::fe1_src_e fe1_src_i,
    input  fetch_pkg::word_t    redirect_addr_i, // Byte address, low bits ignored
    output fetch_pkg::word_t    haddr_o
);

    localparam fetch_pkg::word_t RESET_ADDR = `FETCH_RESET_ADDR;

    fetch_pkg::waddr_t fe0_q, fe0_d;  // Address phase
    fetch_pkg::waddr_t fe1_q, fe1_d;  // Data phase or parked target
    fetch_pkg::waddr_t fe0_incr;
    fetch_pkg::waddr_t target;

    assign fe0_incr = fe0_q + fetch_pkg::waddr_t'(1);
    assign target   = redirect_addr_i[`FETCH_XLEN-1:2];

    always_comb begin
        unique case (fe0_src_i)
            fetch_pkg::FE0_INCR:     fe0_d = fe0_incr;
            fetch_pkg::FE0_REDIRECT: fe0_d = target;
            fetch_pkg::FE0_FROM_FE1: fe0_d = fe1_q;  // Parked redirect moves on
            default:                 fe0_d = fe0_q;
        endcase
    end

    always_comb begin
        unique case (fe1_src_i)
            fetch_pkg::FE1_FROM_FE0: fe1_d = fe0_q;
            fetch_pkg::FE1_PARK:     fe1_d = target;
            default:                 fe1_d = fe1_q;
        endcase
    end

    // FE0 starts at the reset vector
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fe0_q <= RESET_ADDR[`FETCH_XLEN-1:2];
        end else begin
            fe0_q <= fe0_d;
        end
    end

    always_ff @(posedge s_clk_i) begin
        fe1_q <= fe1_d;
    end

    assign haddr_o = {fe0_q, 2'b00};  // Back to a byte address

endmodule

`default_nettype wire

/* source/fetch_ctrl.sv */
/* Fetch control for the two bus phases FE0 and FE1
   Bus address and transfer type are held whenever hready_i is low
   A redirect under a stalled bus is parked in FE1 until hready_i rises
   FE0 leaves reset idle and requests on the first edge after release */

`default_nettype none

`include "fetch_params.svh"

module fetch_ctrl (
    input  logic                     s_clk_i,
    input  logic                     arst_n_i,
    input  logic                     hready_i,
    input  logic                     hresp_i,
    input  logic                     redirect_i,
    input  fetch_pkg::ifb_cnt_t      ifb_cnt_i,    // IFB occupancy
    output fetch_pkg::fe0_src_e      fe0_src_o,    // Next FE0 address select
    output fetch_pkg::fe1_src_e      fe1_src_o,    // Next FE1 address select
    output fetch_pkg::htrans_e       htrans_o,
    output logic                     ifb_push_o,
    output fetch_pkg::fetch_status_e ifb_status_o,
    output logic                     ifb_flush_o
);

    localparam int unsigned DEPTH = `FETCH_IFB_DEPTH;

    logic                 fe0_utd_q, fe0_utd_d; // FE0 request still wanted
    logic                 fe1_utd_q, fe1_utd_d; // FE1 data still wanted
    fetch_pkg::fe1_info_e fe1_inf_q, fe1_inf_d;
    logic                 stall;                // Address phase cannot move
    logic                 park_in_fe1;          // Redirect target waiting in FE1
    logic                 space_1, space_2, space_3;
    logic                 ifb_avail;            // Room guaranteed for one more request

    assign stall       = ~hready_i;
    assign park_in_fe1 = ~fe1_utd_q & (fe1_inf_q == fetch_pkg::FE1_REDIRECT);

    // Free entries counted against words already on the way
    assign space_1   = ifb_cnt_i <= fetch_pkg::ifb_cnt_t'(DEPTH - 1);
    assign space_2   = ifb_cnt_i <= fetch_pkg::ifb_cnt_t'(DEPTH - 2);
    assign space_3   = ifb_cnt_i <= fetch_pkg::ifb_cnt_t'(DEPTH - 3);
    assign ifb_avail = (space_1 & ~fe0_utd_q & ~fe1_utd_q)
                     | (space_2 & (~fe0_utd_q | ~fe1_utd_q))
                     | space_3;

    always_comb begin : fe1_update
        fe1_src_o = fetch_pkg::FE1_HOLD; // Default keeps the data phase
        fe1_utd_d = fe1_utd_q;
        fe1_inf_d = fe1_inf_q;
        if (redirect_i && stall) begin
            // FE0 is frozen by the bus, so the target waits here
            fe1_src_o = fetch_pkg::FE1_PARK;
            fe1_utd_d = 1'b0;
            fe1_inf_d = fetch_pkg::FE1_REDIRECT;
        end else if (redirect_i || (!stall && park_in_fe1)) begin
            fe1_utd_d = 1'b0;                    // Drop data in flight
            fe1_inf_d = fetch_pkg::FE1_NONE;
        end else if (!stall) begin
            fe1_src_o = fetch_pkg::FE1_FROM_FE0; // Address phase done
            fe1_utd_d = fe0_utd_q;
            fe1_inf_d = fetch_pkg::FE1_NONE;
        end
    end

    always_comb begin : fe0_update
        fe0_src_o = fetch_pkg::FE0_HOLD;
        fe0_utd_d = fe0_utd_q;
        if (!stall) begin
            if (redirect_i) begin
                fe0_src_o = fetch_pkg::FE0_REDIRECT; // IFB is flushed on this edge
                fe0_utd_d = 1'b1;
            end else if (park_in_fe1) begin
                fe0_src_o = fetch_pkg::FE0_FROM_FE1; // Release the parked target
                fe0_utd_d = 1'b1;
            end else if (fe0_utd_q) begin
                fe0_src_o = fetch_pkg::FE0_INCR;
                fe0_utd_d = ifb_avail;
            end else begin
                fe0_utd_d = ifb_avail;               // Wait for IFB room
            end
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fe0_utd_q <= 1'b0;
            fe1_utd_q <= 1'b0;
            fe1_inf_q <= fetch_pkg::FE1_NONE;
        end else begin
            fe0_utd_q <= fe0_utd_d;
            fe1_utd_q <= fe1_utd_d;
            fe1_inf_q <= fe1_inf_d;
        end
    end

    assign htrans_o     = fe0_utd_q ? fetch_pkg::HTRANS_NONSEQ : fetch_pkg::HTRANS_IDLE;
    assign ifb_push_o   = fe1_utd_q & hready_i;        // Data phase ends
    assign ifb_status_o = hresp_i ? fetch_pkg::FETCH_BSERR : fetch_pkg::FETCH_VALID;
    assign ifb_flush_o  = redirect_i;

    // Space rule must keep the IFB from overflowing
    a_no_push_full: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        ifb_push_o |-> (ifb_cnt_i < fetch_pkg::ifb_cnt_t'(DEPTH)));

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
/* Types shared across the fetch stage
   Widths come from the params header */

`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] word_t;  // One instruction word
    typedef logic [`FETCH_XLEN-3:0] waddr_t; // Word address, byte offset dropped

    // AHB transfer type, only the two used codes
    typedef enum logic [1:0] {HTRANS_IDLE = 2'b00, HTRANS_NONSEQ = 2'b10} htrans_e;

    typedef enum logic {FETCH_VALID = 1'b0, FETCH_BSERR = 1'b1} fetch_status_e;

    // FE1_REDIRECT marks a parked target in FE1
    typedef enum logic {FE1_NONE = 1'b0, FE1_REDIRECT = 1'b1} fe1_info_e;

    typedef enum logic [1:0] {FE0_HOLD, FE0_INCR, FE0_REDIRECT, FE0_FROM_FE1} fe0_src_e;
    typedef enum logic [1:0] {FE1_HOLD, FE1_FROM_FE0, FE1_PARK} fe1_src_e;

    // Occupancy 0 to depth inclusive
    typedef logic [$clog2(`FETCH_IFB_DEPTH+1)-1:0] ifb_cnt_t;

endpackage

`default_nettype wire

/* source/fetch_params.svh */
/* Build constants of the fetch stage
   FETCH_IFB_DEPTH must stay at 3 or more for the fetch space rule
   FETCH_RESET_ADDR must be word aligned */

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction word and bus width
`define FETCH_XLEN 32

// Number of IFB entries
// The space rule looks three entries ahead
`define FETCH_IFB_DEPTH 4

// Byte address of the first fetch after reset
`define FETCH_RESET_ADDR 32'h0000_0100

`endif
